//--- verif/read_patterns.txt
// address  expected word  flags (bit 0 a line fill is expected, bit 1 reset before the read)
// cold miss, same-line hits, conflict, wrap order, random reads, mid-run reset
00001000 a5a51000 1
00001004 a5a51004 0
00001008 a5a51008 0
0000100c a5a5100c 0
00003000 a5a53000 1
00001000 a5a51000 1
00001004 a5a51004 0
00002048 a5a52048 1
00002040 a5a52040 0
00002044 a5a52044 0
0000204c a5a5204c 0
000050bc a5a550bc 1
000050b0 a5a550b0 0
000050b4 a5a550b4 0
000050b8 a5a550b8 0
1f3a9c24 ba9f9c24 1
7b05e710 dea0e710 1
1f3a9c28 ba9f9c28 0
c4d10e3c 61740e3c 1
7b05e718 dea0e718 0
1f3a9c20 ba9f9c20 0
00001004 a5a51004 3
00001000 a5a51000 0

//--- files.f
src/cache_pkg.sv
src/cache_ifs.sv
src/ahb_read_port.sv
src/line_store.sv
src/miss_ctrl.sv
src/line_fill_master.sv
src/read_cache.sv
verif/clock_gen.sv
verif/mem_model.sv
verif/tb_read_cache.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_read_cache -o sim_read_cache
./obj_dir/sim_read_cache > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- verif/tb_read_cache.sv
module tb_read_cache;
    import cache_pkg::*;

    localparam int max_patterns = 64;

    logic    upstream_intf;
    logic    reset;
    logic    reset_request;
    addr_t   haddr;
    htrans_t htrans;
    logic    hwrite;
    hburst_t hburst;
    word_t   hwdata;
    logic    hready;
    word_t   hrdata;
    addr_t   m_haddr;
    htrans_t m_htrans;
    logic    m_hwrite;
    hburst_t m_hburst;
    word_t   m_hwdata;
    logic    m_hready;
    word_t   m_hrdata;
    int      burst_count;
    addr_t   first_addr;
    hburst_t first_burst;

    // address, expected word and flags, three words per read
    logic [31:0] pattern_words [0:3*max_patterns-1];
    int          num_patterns;
    int          errors;
    int          checks;
    logic        seen_ready;
    word_t       seen_data;
    int          seen_bursts;
    logic        seen_write;
    word_t       seen_wdata;

    clock_gen clocks (.reset_request(reset_request), .upstream_intf(upstream_intf),
                      .reset(reset));

    mem_model memory (
        .upstream_intf(upstream_intf), .reset(reset), .m_haddr(m_haddr),
        .m_htrans(m_htrans), .m_hburst(m_hburst), .m_hready(m_hready),
        .m_hrdata(m_hrdata), .burst_count(burst_count), .first_addr(first_addr),
        .first_burst(first_burst)
    );

    read_cache uut (
        .upstream_intf(upstream_intf), .reset(reset), .haddr(haddr), .htrans(htrans),
        .hwrite(hwrite), .hburst(hburst), .hwdata(hwdata), .hready(hready),
        .hrdata(hrdata), .m_haddr(m_haddr), .m_htrans(m_htrans), .m_hwrite(m_hwrite),
        .m_hburst(m_hburst), .m_hwdata(m_hwdata), .m_hready(m_hready),
        .m_hrdata(m_hrdata)
    );

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_burst(input string name, input hburst_t got, input hburst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // sample the bus in mid-cycle, then move on to the rising edge
    task automatic next_edge();
        @(negedge upstream_intf);
        seen_ready  = hready;
        seen_data   = hrdata;
        seen_bursts = burst_count;
        // the memory side only ever reads
        if (m_htrans != idle) begin
            seen_write = seen_write | m_hwrite;
            seen_wdata = seen_wdata | m_hwdata;
        end
        @(posedge upstream_intf);
    endtask

    task automatic check_read(input int k, input int waits, input int bursts);
        addr_t addr;
        word_t exp_word;
        logic  fill;
        int    errors_before;
        string kind;
        addr          = pattern_words[3*k];
        exp_word      = pattern_words[3*k+1];
        fill          = pattern_words[3*k+2][0];
        errors_before = errors;
        compare_word("hrdata", seen_data, exp_word);
        if (fill) begin
            kind = "miss";
            compare_count("burst_count", bursts, 1);
            compare_addr("m_haddr", first_addr, addr);
            compare_burst("m_hburst", first_burst, wrap4);
            compare_bit("m_hwrite", seen_write, 1'b0);
            compare_word("m_hwdata", seen_wdata, '0);
            if (waits == 0) begin
                errors++;
                $display("read %0d at %h completed without waiting for a line fill", k, addr);
            end
        end else begin
            kind = "hit";
            compare_count("burst_count", bursts, 0);
            if (waits != 0) begin
                errors++;
                $display("read %0d at %h is a hit but stalled %0d cycles", k, addr, waits);
            end
        end
        $display("read %0d addr %h data %h %s %s", k, addr, seen_data, kind,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int   cur;
        int   nxt;
        int   issued;
        int   waits;
        int   start_bursts;
        int   fills;
        logic needs_reset;
        haddr         = '0;
        htrans        = idle;
        hwrite        = 1'b0;
        hburst        = single;
        hwdata        = '0;
        reset_request = 1'b0;
        errors        = 0;
        checks        = 0;
        fills         = 0;
        seen_write    = 1'b0;
        seen_wdata    = '0;
        for (int i = 0; i < 3 * max_patterns; i++) begin
            pattern_words[i] = '1;
        end
        $readmemh("verif/read_patterns.txt", pattern_words);
        num_patterns = 0;
        while (num_patterns < max_patterns &&
               pattern_words[3*num_patterns+2] != 32'hffffffff) begin
            fills += int'(pattern_words[3*num_patterns+2][0]);
            num_patterns++;
        end
        if (num_patterns == 0) begin
            errors++;
            $display("no reads found in verif/read_patterns.txt");
        end
        @(posedge upstream_intf);
        while (reset) @(posedge upstream_intf);
        cur          = -1;
        nxt          = 0;
        start_bursts = burst_count;
        // the next address phase overlaps the current data phase
        while (cur >= 0 || nxt < num_patterns) begin
            needs_reset = (nxt < num_patterns) && pattern_words[3*nxt+2][1];
            issued      = -1;
            if (nxt < num_patterns && !(needs_reset && cur >= 0)) begin
                if (needs_reset) begin
                    reset_request <= 1'b1;
                    repeat (3) @(posedge upstream_intf);
                    reset_request <= 1'b0;
                end
                haddr  <= pattern_words[3*nxt];
                htrans <= nonseq;
                issued = nxt;
                nxt++;
            end else begin
                htrans <= idle;
            end
            waits = 0;
            next_edge();
            while (!seen_ready) begin
                waits++;
                next_edge();
            end
            if (cur >= 0) begin
                check_read(cur, waits, seen_bursts - start_bursts);
            end
            cur          = issued;
            start_bursts = seen_bursts;
            seen_write   = 1'b0;
            seen_wdata   = '0;
        end
        compare_count("burst_count", seen_bursts, fills);
        $display("reads %0d checks %0d errors %0d", num_patterns, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog allows 40 cycles per read plus reset time
    initial begin
        int limit;
        #1;
        limit = num_patterns * 40 + 100;
        repeat (limit) @(posedge upstream_intf);
        $display("timeout waiting for hready after %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end
endmodule

//--- verif/mem_model.sv
module mem_model (
    input  logic               upstream_intf,
    input  logic               reset,
    input  cache_pkg::addr_t   m_haddr,
    input  cache_pkg::htrans_t m_htrans,
    input  cache_pkg::hburst_t m_hburst,
    output logic               m_hready,
    output cache_pkg::word_t   m_hrdata,
    output int                 burst_count,
    output cache_pkg::addr_t   first_addr,
    output cache_pkg::hburst_t first_burst
);
    import cache_pkg::*;

    localparam word_t data_key = 32'ha5a50000;

    logic        data_active;
    addr_t       data_addr;
    int          wait_left;
    int          bursts_served = 0;
    logic [31:0] rnd_state = 32'd13;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign m_hready    = !data_active || (wait_left == 0);
    assign m_hrdata    = (data_active && wait_left == 0) ? (data_addr ^ data_key) : '0;
    assign burst_count = bursts_served;

    always @(posedge upstream_intf) begin
        if (reset) begin
            data_active <= 1'b0;
            wait_left   <= 0;
        end else if (m_hready) begin
            if (m_htrans == nonseq || m_htrans == seq) begin
                data_active <= 1'b1;
                data_addr   <= m_haddr;
                // 0 to 2 wait states per beat
                wait_left   <= int'(rnd_state % 3);
                rnd_state   <= xorshift32(rnd_state);
                if (m_htrans == nonseq) begin
                    bursts_served <= bursts_served + 1;
                    first_addr    <= m_haddr;
                    first_burst   <= m_hburst;
                end
            end else begin
                data_active <= 1'b0;
            end
        end else begin
            wait_left <= wait_left - 1;
        end
    end
endmodule

//--- verif/clock_gen.sv
module clock_gen (
    input  logic reset_request,
    output logic upstream_intf,
    output logic reset
);
    logic power_on;

    initial begin
        upstream_intf = 1'b0;
        forever #5 upstream_intf = ~upstream_intf;
    end

    initial begin
        power_on = 1'b1;
        repeat (10) @(posedge upstream_intf);
        power_on <= 1'b0;
    end

    // power-on reset, or a reset asked for in mid-run
    assign reset = power_on || reset_request;
endmodule

//--- src/read_cache.sv
module read_cache (
    input  logic               upstream_intf,
    input  logic               reset,
    input  cache_pkg::addr_t   haddr,
    input  cache_pkg::htrans_t htrans,
    input  logic               hwrite,
    input  cache_pkg::hburst_t hburst,
    input  cache_pkg::word_t   hwdata,
    output logic               hready,
    output cache_pkg::word_t   hrdata,
    output cache_pkg::addr_t   m_haddr,
    output cache_pkg::htrans_t m_htrans,
    output logic               m_hwrite,
    output cache_pkg::hburst_t m_hburst,
    output cache_pkg::word_t   m_hwdata,
    input  logic               m_hready,
    input  cache_pkg::word_t   m_hrdata
);
    import cache_pkg::*;

    // cpu side is read only, hwrite hburst and hwdata are not decoded
    logic  req_valid;
    addr_t req_addr;
    logic  rsp_ready;
    word_t rsp_data;

    lookup_if lookup_bus ();
    fill_if   fill_bus ();

    ahb_read_port u_read_port (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .haddr         (haddr),
        .htrans        (htrans),
        .hready        (hready),
        .hrdata        (hrdata),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .rsp_ready     (rsp_ready),
        .rsp_data      (rsp_data)
    );

    miss_ctrl u_miss_ctrl (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .rsp_ready     (rsp_ready),
        .rsp_data      (rsp_data),
        .lookup        (lookup_bus.ctrl),
        .fill          (fill_bus.ctrl)
    );

    line_store u_line_store (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .lookup        (lookup_bus.store)
    );

    line_fill_master u_fill_master (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .fill          (fill_bus.master),
        .m_haddr       (m_haddr),
        .m_htrans      (m_htrans),
        .m_hwrite      (m_hwrite),
        .m_hburst      (m_hburst),
        .m_hwdata      (m_hwdata),
        .m_hready      (m_hready),
        .m_hrdata      (m_hrdata)
    );

endmodule

//--- src/line_fill_master.sv
module line_fill_master (
    input  logic               upstream_intf,
    input  logic               reset,
    fill_if.master             fill,
    output cache_pkg::addr_t   m_haddr,
    output cache_pkg::htrans_t m_htrans,
    output logic               m_hwrite,
    output cache_pkg::hburst_t m_hburst,
    output cache_pkg::word_t   m_hwdata,
    input  logic               m_hready,
    input  cache_pkg::word_t   m_hrdata
);
    import cache_pkg::*;

    localparam int base_bits = 32 - word_off_bits - 2;

    // address phase state
    logic                 a_active;
    word_off_t            a_cnt;
    word_off_t            a_off;
    logic [base_bits-1:0] line_base;

    // data phase state, one beat behind
    logic      d_active;
    logic      d_last;
    word_off_t d_off;

    line_t line_buf;
    logic  done_q;

    assign m_htrans = !a_active ? idle : (a_cnt == '0) ? nonseq : seq;
    assign m_hburst = a_active ? wrap4 : single;
    assign m_haddr  = {line_base, a_off, 2'b00};
    assign m_hwrite = 1'b0;
    assign m_hwdata = '0;

    assign fill.fill_done = done_q;
    assign fill.fill_line = line_buf;

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            a_active <= 1'b0;
            a_cnt    <= '0;
            d_active <= 1'b0;
            d_last   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= d_active && d_last && m_hready;
            if (m_hready) begin
                d_active <= a_active;
                d_last   <= a_active && (a_cnt == word_off_t'(words_per_line - 1));
            end
            if (fill.fill_start) begin
                a_active <= 1'b1;
                a_cnt    <= '0;
            end else if (a_active && m_hready) begin
                a_cnt <= a_cnt + 1'b1;
                if (a_cnt == word_off_t'(words_per_line - 1)) begin
                    a_active <= 1'b0;
                end
            end
        end
    end

    // offset wraps inside the 16 byte line on its own
    always_ff @(posedge upstream_intf) begin
        if (fill.fill_start) begin
            line_base <= fill.fill_addr[31 -: base_bits];
            a_off     <= fill.fill_addr[2 +: word_off_bits];
        end else if (a_active && m_hready) begin
            a_off <= a_off + 1'b1;
        end
        if (m_hready) begin
            d_off <= a_off;
        end
        if (d_active && m_hready) begin
            line_buf[{d_off, 5'b00000} +: 32] <= m_hrdata;
        end
    end

    a_hold_on_wait: assert property (
        @(posedge upstream_intf) disable iff (reset)
        (m_htrans != idle && !m_hready) |=> ($stable(m_haddr) && $stable(m_htrans))
    );

endmodule

//--- src/miss_ctrl.sv
module miss_ctrl (
    input  logic             upstream_intf,
    input  logic             reset,
    input  logic             req_valid,
    input  cache_pkg::addr_t req_addr,
    output logic             rsp_ready,
    output cache_pkg::word_t rsp_data,
    lookup_if.ctrl           lookup,
    fill_if.ctrl             fill
);
    import cache_pkg::*;

    localparam int off_lsb   = 2;
    localparam int index_lsb = off_lsb + word_off_bits;
    localparam int tag_lsb   = index_lsb + index_bits;

    word_off_t word_off;
    logic      fill_busy;

    // address split
    assign lookup.tag   = req_addr[tag_lsb +: tag_bits];
    assign lookup.index = req_addr[index_lsb +: index_bits];
    assign word_off     = req_addr[off_lsb +: word_off_bits];

    // the returned word always comes out of the store
    assign rsp_data  = lookup.rd_line[{word_off, 5'b00000} +: 32];
    assign rsp_ready = req_valid && lookup.hit && !fill_busy;

    // one request per miss, the address stays put while stalled
    assign fill.fill_start = req_valid && !lookup.hit && !fill_busy;
    assign fill.fill_addr  = req_addr;

    // filled line goes in as it arrives, hit follows a cycle later
    assign lookup.wr_en   = fill.fill_done && fill_busy;
    assign lookup.wr_line = fill.fill_line;

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            fill_busy <= 1'b0;
        end else if (fill.fill_start) begin
            fill_busy <= 1'b1;
        end else if (fill.fill_done) begin
            fill_busy <= 1'b0;
        end
    end

    // the master never finishes in the cycle a new fill starts
    a_no_start_when_busy: assert property (
        @(posedge upstream_intf) disable iff (reset)
        fill.fill_start |-> !fill.fill_done
    );

    // every fill_done belongs to a pending fill so its line gets written
    a_wr_with_done: assert property (
        @(posedge upstream_intf) disable iff (reset)
        fill.fill_done |-> fill_busy
    );

endmodule

//--- src/line_store.sv
module line_store (
    input  logic  upstream_intf,
    input  logic  reset,
    lookup_if.store lookup
);
    import cache_pkg::*;

    logic [num_lines-1:0] valid;
    tag_t  tag_mem  [num_lines];
    line_t data_mem [num_lines];

    logic  entry_valid;
    tag_t  entry_tag;

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            valid <= '0;
        end else if (lookup.wr_en) begin
            valid[lookup.index] <= 1'b1;
        end
    end

    // tag and line arrays
    always_ff @(posedge upstream_intf) begin
        if (lookup.wr_en) begin
            tag_mem[lookup.index]  <= lookup.tag;
            data_mem[lookup.index] <= lookup.wr_line;
        end
    end

    assign entry_valid = valid[lookup.index];
    assign entry_tag   = tag_mem[lookup.index];

    // direct mapped so a single compare
    assign lookup.hit     = entry_valid && (entry_tag == lookup.tag);
    assign lookup.rd_line = data_mem[lookup.index];

endmodule

//--- src/ahb_read_port.sv
module ahb_read_port (
    input  logic              upstream_intf,
    input  logic              reset,
    input  cache_pkg::addr_t  haddr,
    input  cache_pkg::htrans_t htrans,
    output logic              hready,
    output cache_pkg::word_t  hrdata,
    output logic              req_valid,
    output cache_pkg::addr_t  req_addr,
    input  logic              rsp_ready,
    input  cache_pkg::word_t  rsp_data
);
    import cache_pkg::*;

    logic addr_phase;

    // only nonseq and seq carry a transfer
    assign addr_phase = (htrans == nonseq) || (htrans == seq);

    // free outside a data phase, else wait on the controller
    assign hready = !req_valid || rsp_ready;
    assign hrdata = rsp_data;

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (hready) begin
            // a completing data phase may overlap the next address phase
            req_valid <= addr_phase;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (hready && addr_phase) begin
            req_addr <= haddr;
        end
    end

    // a completing data phase carries a known word
    a_hrdata_known: assert property (
        @(posedge upstream_intf) disable iff (reset)
        (req_valid && hready) |-> !$isunknown(hrdata)
    );

endmodule

//--- src/cache_ifs.sv
// tag lookup and line write between controller and store
interface lookup_if;
    import cache_pkg::*;

    index_t index;
    tag_t   tag;
    logic   wr_en;
    line_t  wr_line;
    logic   hit;
    line_t  rd_line;

    modport ctrl (
        output index,
        output tag,
        output wr_en,
        output wr_line,
        input  hit,
        input  rd_line
    );

    modport store (
        input  index,
        input  tag,
        input  wr_en,
        input  wr_line,
        output hit,
        output rd_line
    );
endinterface

// line fill request and completion
interface fill_if;
    import cache_pkg::*;

    logic  fill_start;
    addr_t fill_addr;
    logic  fill_done;
    line_t fill_line;

    modport ctrl (
        output fill_start,
        output fill_addr,
        input  fill_done,
        input  fill_line
    );

    modport master (
        input  fill_start,
        input  fill_addr,
        output fill_done,
        output fill_line
    );
endinterface

//--- src/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int cache_bytes    = 8192;
    localparam int line_bits      = 128;
    localparam int words_per_line = line_bits / 32;
    localparam int num_lines      = cache_bytes * 8 / line_bits;
    localparam int index_bits     = $clog2(num_lines);
    localparam int word_off_bits  = $clog2(words_per_line);
    // two byte bits below the word offset
    localparam int tag_bits       = 32 - index_bits - word_off_bits - 2;

    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            word_t;
    // word 0 in the low bits
    typedef logic [line_bits-1:0]   line_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [word_off_bits-1:0] word_off_t;

    // ahb transfer types
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonseq = 2'b10,
        seq    = 2'b11
    } htrans_t;

    // the short ahb burst codes
    typedef enum logic [2:0] {
        single = 3'b000,
        incr   = 3'b001,
        wrap4  = 3'b010,
        incr4  = 3'b011
    } hburst_t;

endpackage
